//--- hw/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // Operand and result width, fixed by RV32.
    localparam int XLEN  = 32;
    localparam int TAG_W = 4;

    // Encoded in RV32M funct3 order, so bit 2 separates the divide family.
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } md_op_e;

    typedef struct packed {
        md_op_e            op;
        logic [XLEN-1:0]   rs1;
        logic [XLEN-1:0]   rs2;
        logic [TAG_W-1:0]  tag;
    } md_req_t;

    typedef struct packed {
        logic [XLEN-1:0]   data;
        logic [TAG_W-1:0]  tag;
    } md_rsp_t;

    function automatic logic is_div_op(input md_op_e op);
        logic hit;
        hit = (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
        return hit;
    endfunction

    // Two's complement negation when neg is set, used for magnitudes and sign fixes.
    function automatic logic [XLEN-1:0] cond_neg(
        input logic [XLEN-1:0] value,
        input logic            neg
    );
        logic [XLEN-1:0] res;
        res = neg ? (~value + 1'b1) : value;
        return res;
    endfunction

endpackage

`default_nettype wire

//--- hw/iter_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module iter_multiplier
    import muldiv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid_i,
    input  wire  md_req_t req_i,
    input  wire           cancel_i,
    input  wire           grant_i,
    output logic          busy_o,
    output logic          done_o,
    output md_rsp_t       rsp_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HOLD
    } mul_state_e;

    localparam logic [4:0] FIX_STEP = 5'd16;

    mul_state_e         state_q;
    logic [4:0]         step_q;
    logic [XLEN-1:0]    mcand_q;
    logic [2*XLEN-1:0]  acc_q;
    logic               neg_q;
    logic               hi_q;
    md_rsp_t            rsp_q;

    logic               req_is_mul;
    logic               rs1_neg;
    logic               rs2_neg;
    logic               accept;
    logic [XLEN+1:0]    pp;
    logic [XLEN+1:0]    sum;
    logic [2*XLEN-1:0]  prod;

    assign req_is_mul = !is_div_op(req_i.op);
    // MULHSU treats only rs1 as signed. MUL needs no sign handling for its low half.
    assign rs1_neg = ((req_i.op == OP_MULH) || (req_i.op == OP_MULHSU)) && req_i.rs1[XLEN-1];
    assign rs2_neg = (req_i.op == OP_MULH) && req_i.rs2[XLEN-1];
    assign accept  = req_valid_i && req_is_mul && (state_q == ST_IDLE) && !cancel_i;

    // The low half of acc_q starts as the multiplier and is shifted out two
    // bits per cycle while the partial products build up in the upper bits.
    assign pp   = ({2'b00, mcand_q} & {(XLEN+2){acc_q[0]}})
                + ({1'b0, mcand_q, 1'b0} & {(XLEN+2){acc_q[1]}});
    assign sum  = {2'b00, acc_q[2*XLEN-1:XLEN]} + pp;
    assign prod = neg_q ? (~acc_q + 1'b1) : acc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
        end else if (cancel_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_RUN;
                        step_q  <= '0;
                    end
                end
                ST_RUN: begin
                    if (step_q == FIX_STEP) begin
                        state_q <= ST_HOLD;
                    end
                    step_q <= step_q + 5'd1;
                end
                ST_HOLD: begin
                    if (grant_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mcand_q   <= cond_neg(req_i.rs1, rs1_neg);
            acc_q     <= {{XLEN{1'b0}}, cond_neg(req_i.rs2, rs2_neg)};
            neg_q     <= rs1_neg ^ rs2_neg;
            hi_q      <= (req_i.op != OP_MUL);
            rsp_q.tag <= req_i.tag;
        end else if (state_q == ST_RUN) begin
            if (step_q == FIX_STEP) begin
                rsp_q.data <= hi_q ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
            end else begin
                acc_q <= {sum, acc_q[XLEN-1:2]};
            end
        end
    end

    assign busy_o = (state_q != ST_IDLE);
    assign done_o = (state_q == ST_HOLD) && !cancel_i;
    assign rsp_o  = rsp_q;

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i && req_is_mul |-> !busy_o);

endmodule

`default_nettype wire

//--- hw/iter_divider.sv
`timescale 1ns/10ps
`default_nettype none

module iter_divider
    import muldiv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid_i,
    input  wire  md_req_t req_i,
    input  wire           cancel_i,
    input  wire           grant_i,
    output logic          busy_o,
    output logic          done_o,
    output md_rsp_t       rsp_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HOLD
    } div_state_e;

    localparam logic [5:0] LAST_STEP = 6'd32;

    div_state_e       state_q;
    logic [5:0]       step_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  dsr_q;
    logic             op1_sign_q;
    logic             op2_sign_q;
    logic             signed_q;
    logic             is_rem_q;
    logic             dsr_zero_q;
    md_rsp_t          rsp_q;

    logic             req_is_div;
    logic             req_signed;
    logic             accept;
    logic [XLEN:0]    trial;
    logic [XLEN:0]    diff;
    logic             fits;
    logic             quo_neg;
    logic             rem_neg;
    logic [XLEN-1:0]  result;

    assign req_is_div = is_div_op(req_i.op);
    assign req_signed = (req_i.op == OP_DIV) || (req_i.op == OP_REM);
    assign accept     = req_valid_i && req_is_div && (state_q == ST_IDLE) && !cancel_i;

    // Restoring step: shift the next dividend bit into the partial remainder
    // and subtract the divisor with one extra bit so no borrow is lost.
    assign trial = {rem_q, quo_q[XLEN-1]};
    assign diff  = trial - {1'b0, dsr_q};
    assign fits  = !diff[XLEN];

    // A zero divisor leaves the all-ones quotient unsigned, as RISC-V requires.
    assign quo_neg = signed_q && (op1_sign_q ^ op2_sign_q) && !dsr_zero_q;
    assign rem_neg = signed_q && op1_sign_q;
    assign result  = is_rem_q ? cond_neg(rem_q, rem_neg) : cond_neg(quo_q, quo_neg);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
        end else if (cancel_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_RUN;
                        step_q  <= '0;
                    end
                end
                ST_RUN: begin
                    if (step_q == LAST_STEP) begin
                        state_q <= ST_HOLD;
                    end
                    step_q <= step_q + 6'd1;
                end
                ST_HOLD: begin
                    if (grant_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            quo_q      <= cond_neg(req_i.rs1, req_signed && req_i.rs1[XLEN-1]);
            dsr_q      <= cond_neg(req_i.rs2, req_signed && req_i.rs2[XLEN-1]);
            rem_q      <= '0;
            op1_sign_q <= req_i.rs1[XLEN-1];
            op2_sign_q <= req_i.rs2[XLEN-1];
            signed_q   <= req_signed;
            is_rem_q   <= (req_i.op == OP_REM) || (req_i.op == OP_REMU);
            dsr_zero_q <= (req_i.rs2 == '0);
            rsp_q.tag  <= req_i.tag;
        end else if (state_q == ST_RUN) begin
            if (step_q == LAST_STEP) begin
                // The extra cycle after 32 steps applies the sign correction.
                rsp_q.data <= result;
            end else begin
                rem_q <= fits ? diff[XLEN-1:0] : trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], fits};
            end
        end
    end

    assign busy_o = (state_q != ST_IDLE);
    // A cancel drops the held result before the arbiter can take it.
    assign done_o = (state_q == ST_HOLD) && !cancel_i;
    assign rsp_o  = rsp_q;

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i && req_is_div |-> !busy_o);

    // An ungranted result stays offered and unchanged until a cancel.
    a_done_holds: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && !grant_i |=> $stable(rsp_o) && (done_o || cancel_i));

endmodule

`default_nettype wire

//--- hw/result_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module result_arbiter
    import muldiv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           mul_done_i,
    input  wire  md_rsp_t mul_rsp_i,
    input  wire           div_done_i,
    input  wire  md_rsp_t div_rsp_i,
    output logic          mul_grant_o,
    output logic          div_grant_o,
    output logic          rsp_valid_o,
    output md_rsp_t       rsp_o
);

    // Set when the divider wins the next tie, i.e. the multiplier won last.
    logic     div_prio_q;
    logic     rsp_valid_q;
    md_rsp_t  rsp_q;

    assign div_grant_o = div_done_i && (div_prio_q || !mul_done_i);
    assign mul_grant_o = mul_done_i && (!div_prio_q || !div_done_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_prio_q  <= 1'b1;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= mul_grant_o || div_grant_o;
            if (mul_grant_o || div_grant_o) begin
                div_prio_q <= mul_grant_o;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_grant_o) begin
            rsp_q <= div_rsp_i;
        end else if (mul_grant_o) begin
            rsp_q <= mul_rsp_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_grant_o && div_grant_o));

    // The engine must leave its hold state right after a grant.
    a_grant_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (mul_grant_o |=> !mul_grant_o) and (div_grant_o |=> !div_grant_o));

endmodule

`default_nettype wire

//--- hw/muldiv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_unit
    import muldiv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid_i,
    input  wire  md_req_t req_i,
    input  wire           cancel_i,
    output logic          mul_busy_o,
    output logic          div_busy_o,
    output logic          rsp_valid_o,
    output md_rsp_t       rsp_o
);

    logic     mul_done;
    logic     mul_grant;
    md_rsp_t  mul_rsp;
    logic     div_done;
    logic     div_grant;
    md_rsp_t  div_rsp;

    // Both engines see every request and pick out their own ops.
    iter_multiplier u_mul (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .cancel_i    (cancel_i),
        .grant_i     (mul_grant),
        .busy_o      (mul_busy_o),
        .done_o      (mul_done),
        .rsp_o       (mul_rsp)
    );

    iter_divider u_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .cancel_i    (cancel_i),
        .grant_i     (div_grant),
        .busy_o      (div_busy_o),
        .done_o      (div_done),
        .rsp_o       (div_rsp)
    );

    result_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .mul_done_i  (mul_done),
        .mul_rsp_i   (mul_rsp),
        .div_done_i  (div_done),
        .div_rsp_i   (div_rsp),
        .mul_grant_o (mul_grant),
        .div_grant_o (div_grant),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

//--- sim/muldiv_ref.svh
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// Expected result of one RV32M operation, written from the ISA rules.
// Products are formed on 64 bits with explicit sign or zero extension.
function automatic logic [31:0] muldiv_ref(
    input md_op_e      op,
    input logic [31:0] a,
    input logic [31:0] b
);
    logic [63:0] a_sx;
    logic [63:0] b_sx;
    logic [63:0] a_zx;
    logic [63:0] b_zx;
    logic [63:0] prod;
    logic        overflow;
    logic [31:0] res;
    a_sx     = {{32{a[31]}}, a};
    b_sx     = {{32{b[31]}}, b};
    a_zx     = {32'h0, a};
    b_zx     = {32'h0, b};
    overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    prod     = '0;
    res      = '0;
    case (op)
        OP_MUL: begin
            prod = a_zx * b_zx;
            res  = prod[31:0];
        end
        OP_MULH: begin
            prod = a_sx * b_sx;
            res  = prod[63:32];
        end
        OP_MULHSU: begin
            prod = a_sx * b_zx;
            res  = prod[63:32];
        end
        OP_MULHU: begin
            prod = a_zx * b_zx;
            res  = prod[63:32];
        end
        OP_DIV: begin
            if (b == '0) begin
                res = '1;
            end else if (overflow) begin
                res = a;
            end else begin
                res = $signed(a) / $signed(b);
            end
        end
        OP_DIVU: begin
            res = (b == '0) ? '1 : a / b;
        end
        OP_REM: begin
            if (b == '0) begin
                res = a;
            end else if (overflow) begin
                res = '0;
            end else begin
                res = $signed(a) % $signed(b);
            end
        end
        default: begin
            res = (b == '0) ? a : a % b;
        end
    endcase
    return res;
endfunction

// Galois LFSR for x^32 + x^22 + x^2 + x + 1, shifting right.
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
endfunction

`endif

//--- sim/tb_muldiv.sv
`timescale 1ns/10ps
`default_nettype none

module tb_muldiv
    import muldiv_pkg::*;
();

    localparam int DIV_LATENCY = 34;
    localparam int MUL_LATENCY = 18;
    localparam int WAIT_LIMIT  = 200;
    localparam int NUM_RANDOM  = 200;

    logic             clk;
    logic             rst_n;
    logic             req_valid;
    md_req_t          req;
    logic             cancel;
    logic             mul_busy;
    logic             div_busy;
    logic             rsp_valid;
    md_rsp_t          rsp;

    logic [31:0]      lfsr_q;
    int               cycle = 0;
    int               errors;
    int               checks;
    int               timeouts;
    logic [XLEN-1:0]  exp_data   [2**TAG_W];
    bit               pending    [2**TAG_W];
    int               strobe_cyc [2**TAG_W];
    int               resp_cyc   [2**TAG_W];

    `include "muldiv_ref.svh"

    muldiv_unit dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .cancel_i    (cancel),
        .mul_busy_o  (mul_busy),
        .div_busy_o  (div_busy),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Responses are sampled on the falling edge, where they are stable.
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            checks = checks + 1;
            if (!pending[rsp.tag]) begin
                errors = errors + 1;
                $display("Response with tag %0d at %0t was not expected", rsp.tag, $time);
            end else if (rsp.data !== exp_data[rsp.tag]) begin
                errors = errors + 1;
                $display("** Error at %0t: rsp_o.data (tag %0d) expected %h, got %h",
                         $time, rsp.tag, exp_data[rsp.tag], rsp.data);
            end
            pending[rsp.tag]  = 1'b0;
            resp_cyc[rsp.tag] = cycle;
        end
    end

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits   = {bits[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return bits;
    endfunction

    function automatic logic targets_divider(input md_op_e op);
        return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
    endfunction

    task automatic note_timeout(input string what);
        timeouts = timeouts + 1;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic issue(
        input md_op_e           op,
        input logic [XLEN-1:0]  a,
        input logic [XLEN-1:0]  b,
        input logic [TAG_W-1:0] tag
    );
        int   waited;
        logic to_div;
        waited = 0;
        to_div = targets_divider(op);
        @(posedge clk);
        while (to_div ? div_busy : mul_busy) begin
            if (waited == WAIT_LIMIT) begin
                note_timeout($sformatf("engine stayed busy, tag %0d not issued", tag));
                return;
            end
            waited++;
            @(posedge clk);
        end
        exp_data[tag] = muldiv_ref(op, a, b);
        pending[tag]  = 1'b1;
        req_valid <= 1'b1;
        req       <= '{op: op, rs1: a, rs2: b, tag: tag};
        @(posedge clk);
        req_valid <= 1'b0;
        // The DUT takes the strobe on this edge, and cycle still holds the count before it.
        strobe_cyc[tag] = cycle + 1;
    endtask

    task automatic wait_response(input logic [TAG_W-1:0] tag);
        int waited;
        waited = 0;
        while (pending[tag]) begin
            if (waited == WAIT_LIMIT) begin
                note_timeout($sformatf("no response for tag %0d", tag));
                pending[tag] = 1'b0;
                return;
            end
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic run_one(
        input md_op_e           op,
        input logic [XLEN-1:0]  a,
        input logic [XLEN-1:0]  b,
        input logic [TAG_W-1:0] tag
    );
        issue(op, a, b, tag);
        wait_response(tag);
    endtask

    task automatic random_ops();
        logic [31:0]     op_bits;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op_bits = take_bits(3);
            a       = take_bits(32);
            b       = take_bits(32);
            run_one(md_op_e'(op_bits[2:0]), a, b, i[TAG_W-1:0]);
        end
    endtask

    task automatic corner_ops();
        logic [XLEN-1:0] corners [5];
        int              n;
        corners = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        n = 0;
        for (int o = 0; o < 8; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    run_one(md_op_e'(o[2:0]), corners[i], corners[j], n[TAG_W-1:0]);
                    n++;
                end
            end
        end
    endtask

    task automatic mul_overtakes_div();
        issue(OP_DIVU, 32'hDEAD_BEEF, 32'h0000_0123, 4'd1);
        issue(OP_MULHSU, 32'h8765_4321, 32'h1234_5678, 4'd2);
        // Both engines have accepted by now and must report busy.
        @(posedge clk);
        if (mul_busy !== 1'b1) begin
            errors = errors + 1;
            $display("** Error at %0t: mul_busy_o expected 1, got %b", $time, mul_busy);
        end
        if (div_busy !== 1'b1) begin
            errors = errors + 1;
            $display("** Error at %0t: div_busy_o expected 1, got %b", $time, div_busy);
        end
        wait_response(4'd1);
        wait_response(4'd2);
        if (resp_cyc[2] >= resp_cyc[1]) begin
            errors = errors + 1;
            $display("The multiply response did not arrive before the divide response");
        end
        // Both results have been granted, so both engines are idle again.
        if (mul_busy !== 1'b0) begin
            errors = errors + 1;
            $display("** Error at %0t: mul_busy_o expected 0, got %b", $time, mul_busy);
        end
        if (div_busy !== 1'b0) begin
            errors = errors + 1;
            $display("** Error at %0t: div_busy_o expected 0, got %b", $time, div_busy);
        end
    endtask

    task automatic tie_goes_to_div();
        // The priority flag starts at the divider only after reset.
        apply_reset();
        issue(OP_REM, 32'hF000_0001, 32'h0000_0007, 4'd3);
        repeat (14) @(posedge clk);
        issue(OP_MUL, 32'h0001_0003, 32'hFFFF_FFF9, 4'd4);
        wait_response(4'd3);
        wait_response(4'd4);
        if (resp_cyc[4] != resp_cyc[3] + 1) begin
            errors = errors + 1;
            $display("Tied results did not arrive as divide then multiply in consecutive cycles");
        end
    endtask

    task automatic cancel_divide();
        int waited;
        issue(OP_DIV, 32'h1234_5678, 32'h0000_0009, 4'd5);
        repeat (5) @(posedge clk);
        if (!div_busy) begin
            errors = errors + 1;
            $display("div_busy_o was low at %0t while a divide was running", $time);
        end
        // Any response with this tag is now flagged by the checker.
        pending[5] = 1'b0;
        cancel <= 1'b1;
        @(posedge clk);
        cancel <= 1'b0;
        waited = 0;
        while (div_busy) begin
            if (waited == 4) begin
                note_timeout("div_busy_o did not fall after cancel");
                break;
            end
            waited++;
            @(posedge clk);
        end
        repeat (DIV_LATENCY + 4) @(posedge clk);
        run_one(OP_DIV, 32'h8000_0000, 32'h0000_0003, 4'd6);
    endtask

    task automatic lone_latency();
        run_one(OP_DIV, 32'h0765_4321, 32'hFFFF_FF10, 4'd7);
        if (resp_cyc[7] - strobe_cyc[7] != DIV_LATENCY) begin
            errors = errors + 1;
            $display("Divide latency was %0d cycles instead of %0d",
                     resp_cyc[7] - strobe_cyc[7], DIV_LATENCY);
        end
        run_one(OP_MULH, 32'hC000_0005, 32'h7000_0003, 4'd8);
        if (resp_cyc[8] - strobe_cyc[8] != MUL_LATENCY) begin
            errors = errors + 1;
            $display("Multiply latency was %0d cycles instead of %0d",
                     resp_cyc[8] - strobe_cyc[8], MUL_LATENCY);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        cancel    = 1'b0;
        lfsr_q    = 32'h1418_db4a;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        apply_reset();
        random_ops();
        corner_ops();
        mul_overtakes_div();
        tie_goes_to_div();
        cancel_divide();
        lone_latency();
        repeat (4) @(posedge clk);
        $display("Responses checked: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+sim
hw/muldiv_pkg.sv
hw/iter_multiplier.sv
hw/iter_divider.sv
hw/result_arbiter.sv
hw/muldiv_unit.sv
sim/tb_muldiv.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_muldiv
FLIST    := flist.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FLIST)) $(wildcard sim/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
